// File: logic/fpga_subsys_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register subsystem package
// Widths, register map addresses and the structs shared between the blocks
////////////////////////////////////////////////////////////////////////////
package fpga_subsys_pkg;

    localparam int NUM_MOTORS = 4;                    // Drive motors, servos and fault inputs
    localparam int ADDR_W     = 6;                    // Register address width
    localparam int DATA_W     = 8;                    // Register data width

    typedef logic [ADDR_W-1:0] reg_addr_t;            // Register address
    typedef logic [DATA_W-1:0] reg_data_t;            // Register data

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////
    localparam reg_addr_t ADDR_DRIVE0   = 6'h00;      // Drive commands 0x00 to 0x03
    localparam reg_addr_t ADDR_SERVO0   = 6'h04;      // Servo positions 0x04 to 0x07
    localparam reg_addr_t ADDR_LED_CTRL = 6'h08;      // LED test enable and values
    localparam reg_addr_t ADDR_LINK     = 6'h09;      // Host link flags
    localparam reg_addr_t ADDR_FAULT    = 6'h0A;      // Live fault inputs, read only

    localparam logic DEBUG_LAMP_ON = 1'b1;            // Debug lamp level outside LED test

    // One drive motor command byte, sent whole on the UART
    typedef struct packed {
        logic       brake;                            // Brake request
        logic       enable;                           // Motor enable
        logic       direction;                        // Spin direction
        logic [4:0] speed;                            // Speed setting
    } drive_cmd_t;

    // One register access from the SPI link
    typedef struct packed {
        reg_addr_t  address;                          // Target register
        logic       write_en;                         // One clock write strobe
        reg_data_t  wr_data;                          // Write data
        logic       read_en;                          // One clock read strobe
    } reg_access_t;

    // Status lamps, fault lamp in the MSB
    typedef struct packed {
        logic fault;                                  // Any motor fault
        logic pi;                                     // Pi link up
        logic ps4;                                    // PS4 link up
        logic debug;                                  // Debug lamp
    } status_led_t;

endpackage

// File: logic/spi_slave.sv
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 slave
// Turns two-byte command/data frames into register read and write strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_slave import fpga_subsys_pkg::*; (
    input  logic        clock,                        // System clock
    input  logic        rst_n,                        // Async reset, active low
    input  logic        spi_clock,                    // SPI clock from host
    input  logic        cs_n,                         // Chip select, active low
    input  logic        mosi,                         // Host to slave data
    output logic        miso,                         // Slave to host data
    output reg_access_t reg_access,                   // Register access strobes
    input  reg_data_t   rd_data                       // Readback from register file
);

    logic [2:0] sclk_q;                               // Clock sync plus edge stage
    logic [1:0] cs_q;                                 // Chip select sync
    logic [1:0] mosi_q;                               // Data sync
    logic       sclk_rise;                            // Synced rising edge
    logic       sclk_fall;                            // Synced falling edge
    logic       cs_s;                                 // Synced chip select
    logic       mosi_s;                               // Synced data bit
    logic [3:0] bit_cnt;                              // Bits received this frame
    logic [6:0] shift_in;                             // Receive shifter
    logic       is_write;                             // Command byte asked for a write
    logic       rd_load;                              // Readback is valid this clock
    logic [7:0] shift_out;                            // Transmit shifter

    ////////////////////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q <= '0;
            cs_q   <= '1;                             // Idle deselected
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_clock};
            cs_q   <= {cs_q[0], cs_n};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_s      = cs_q[1];
    assign mosi_s    = mosi_q[1];

    ////////////////////////////////////////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            shift_in   <= '0;
            is_write   <= 1'b0;
            reg_access <= '0;
        end else begin
            reg_access.read_en  <= 1'b0;              // Strobes last one clock
            reg_access.write_en <= 1'b0;
            if (cs_s) begin
                bit_cnt <= '0;                        // Short frame is dropped here
            end else if (sclk_rise) begin
                shift_in <= {shift_in[5:0], mosi_s};  // MSB first
                bit_cnt  <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd7) begin            // Command byte complete
                    is_write            <= shift_in[6];
                    reg_access.address  <= {shift_in[4:0], mosi_s};
                    reg_access.read_en  <= ~shift_in[6];
                end
                if (bit_cnt == 4'd15) begin           // Data byte complete
                    reg_access.wr_data  <= {shift_in[6:0], mosi_s};
                    reg_access.write_en <= is_write;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transmit side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_load   <= 1'b0;
            shift_out <= '0;
            miso      <= 1'b0;
        end else begin
            rd_load <= reg_access.read_en;            // rd_data lands one clock later
            if (cs_s) begin
                shift_out <= '0;
                miso      <= 1'b0;                    // Low while deselected
            end else if (rd_load) begin
                shift_out <= rd_data;
            end else if (sclk_fall) begin
                miso      <= shift_out[7];            // MSB out first
                shift_out <= {shift_out[6:0], 1'b0};
            end
        end
    end

endmodule

// File: logic/reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Register file
// Address decode, registered readback and status lamp selection
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file import fpga_subsys_pkg::*; (
    input  logic                             clock,          // System clock
    input  logic                             rst_n,          // Async reset, active low
    input  reg_access_t                      reg_access,     // Strobes from SPI slave
    output reg_data_t                        rd_data,        // Registered readback
    input  logic        [NUM_MOTORS-1:0]     motor_fault,    // Live fault inputs
    output drive_cmd_t  [NUM_MOTORS-1:0]     drive_cmd,      // To the UARTs
    output reg_data_t   [NUM_MOTORS-1:0]     servo_position, // To the PWMs
    output status_led_t                      status_led      // Lamp outputs
);

    logic        led_test_en;                        // LED test mode
    status_led_t led_test_val;                       // Lamp values in test mode
    logic        link_pi;                            // Pi connected flag
    logic        link_ps4;                           // PS4 connected flag
    logic        hit_drive;                          // Address in drive block
    logic        hit_servo;                          // Address in servo block
    reg_data_t   rd_mux;                             // Readback select

    assign hit_drive = reg_access.address[ADDR_W-1:2] == ADDR_DRIVE0[ADDR_W-1:2];
    assign hit_servo = reg_access.address[ADDR_W-1:2] == ADDR_SERVO0[ADDR_W-1:2];

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            drive_cmd      <= '0;
            servo_position <= '0;
            led_test_en    <= 1'b0;
            led_test_val   <= '0;
            link_pi        <= 1'b0;
            link_ps4       <= 1'b0;
        end else if (reg_access.write_en) begin
            if (hit_drive) begin
                drive_cmd[reg_access.address[1:0]] <= drive_cmd_t'(reg_access.wr_data);
            end else if (hit_servo) begin
                servo_position[reg_access.address[1:0]] <= reg_access.wr_data;
            end else if (reg_access.address == ADDR_LED_CTRL) begin
                led_test_en  <= reg_access.wr_data[4];
                led_test_val <= status_led_t'(reg_access.wr_data[3:0]);
            end else if (reg_access.address == ADDR_LINK) begin
                link_pi  <= reg_access.wr_data[0];
                link_ps4 <= reg_access.wr_data[1];
            end                                      // Fault and unmapped ignored
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_mux = '0;                                 // Unmapped reads 0
        if (hit_drive) begin
            rd_mux = drive_cmd[reg_access.address[1:0]];
        end else if (hit_servo) begin
            rd_mux = servo_position[reg_access.address[1:0]];
        end else if (reg_access.address == ADDR_LED_CTRL) begin
            rd_mux[4:0] = {led_test_en, led_test_val};
        end else if (reg_access.address == ADDR_LINK) begin
            rd_mux[1:0] = {link_ps4, link_pi};
        end else if (reg_access.address == ADDR_FAULT) begin
            rd_mux[NUM_MOTORS-1:0] = motor_fault;    // Live inputs
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (reg_access.read_en) begin
            rd_data <= rd_mux;                       // Valid one clock after strobe
        end
    end

    // Lamp select, test values override everything
    always_comb begin
        if (led_test_en) begin
            status_led = led_test_val;
        end else begin
            status_led = '{fault: |motor_fault, pi: link_pi, ps4: link_ps4,
                           debug: DEBUG_LAMP_ON};
        end
    end

endmodule

// File: logic/uart_tx.sv
////////////////////////////////////////////////////////////////////////////
// Free-running 8N1 UART transmitter
// Repeats one drive motor command byte back to back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx import fpga_subsys_pkg::*; #(
    parameter int BAUD_DIVISION = 116                // Clocks per bit
) (
    input  logic       clock,                        // System clock
    input  logic       rst_n,                        // Async reset, active low
    input  drive_cmd_t tx_data,                      // Command byte to repeat
    output logic       tx                            // Serial line
);

    localparam int CNT_W = $clog2(BAUD_DIVISION);

    logic [CNT_W-1:0] baud_cnt;                      // Clocks into current bit
    logic [3:0]       bit_idx;                       // 0 start, 1..8 data, 9 stop
    reg_data_t        data_q;                        // Byte latched at start bit
    logic             bit_end;                       // Last clock of a bit

    assign bit_end = baud_cnt == CNT_W'(BAUD_DIVISION - 1);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= CNT_W'(BAUD_DIVISION - 1);   // First clock out starts a frame
            bit_idx  <= 4'd9;
            data_q   <= '0;
            tx       <= 1'b1;                        // Line idles high
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9) begin               // Stop done, start next frame
                data_q  <= tx_data;
                tx      <= 1'b0;
                bit_idx <= 4'd0;
            end else if (bit_idx == 4'd8) begin      // Last data bit done
                tx      <= 1'b1;
                bit_idx <= 4'd9;
            end else begin
                tx      <= data_q[bit_idx[2:0]];     // LSB first
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// File: logic/servo_pwm.sv
////////////////////////////////////////////////////////////////////////////
// Servo PWM, 8-bit duty over a 256 clock period
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module servo_pwm import fpga_subsys_pkg::*; (
    input  logic      clock,                         // System clock
    input  logic      rst_n,                         // Async reset, active low
    input  reg_data_t ratio,                         // High clocks per period
    output logic      pwm                            // Duty waveform
);

    reg_data_t cnt;                                  // Free-running period counter
    reg_data_t ratio_q;                              // Ratio for current period

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            ratio_q <= '0;
            pwm     <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;                       // Wraps every 256
            if (cnt == '1) begin
                ratio_q <= ratio;                    // Reload on wrap
            end
            pwm <= cnt < ratio_q;
        end
    end

endmodule

// File: logic/fpga_subsys.sv
////////////////////////////////////////////////////////////////////////////
// Control board register subsystem
// SPI slave, register file, drive motor UARTs and servo PWMs
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpga_subsys import fpga_subsys_pkg::*; #(
    parameter int BAUD_DIVISION = 116                // UART clocks per bit
) (
    input  logic                  clock,             // System clock
    input  logic                  rst_n,             // Async reset, active low
    input  logic                  spi_clock,         // SPI clock
    input  logic                  cs_n,              // SPI chip select
    input  logic                  mosi,              // SPI host data
    output logic                  miso,              // SPI slave data
    input  logic [NUM_MOTORS-1:0] motor_fault,       // Motor fault inputs
    output logic [NUM_MOTORS-1:0] sd_uart,           // Drive motor UART lines
    output logic [NUM_MOTORS-1:0] servo_pwm,         // Servo PWM lines
    output status_led_t           status_led         // Status lamps
);

    reg_access_t                  reg_access;        // SPI to register file
    reg_data_t                    rd_data;           // Readback to SPI
    drive_cmd_t [NUM_MOTORS-1:0]  drive_cmd;         // Drive command registers
    reg_data_t  [NUM_MOTORS-1:0]  servo_position;    // Servo position registers

    spi_slave u_spi (
        .clock      (clock),
        .rst_n      (rst_n),
        .spi_clock  (spi_clock),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso),
        .reg_access (reg_access),
        .rd_data    (rd_data)
    );

    reg_file u_regs (
        .clock          (clock),
        .rst_n          (rst_n),
        .reg_access     (reg_access),
        .rd_data        (rd_data),
        .motor_fault    (motor_fault),
        .drive_cmd      (drive_cmd),
        .servo_position (servo_position),
        .status_led     (status_led)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per motor outputs
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_MOTORS; i++) begin : gen_motor
        uart_tx #(.BAUD_DIVISION(BAUD_DIVISION)) u_uart (
            .clock   (clock),
            .rst_n   (rst_n),
            .tx_data (drive_cmd[i]),
            .tx      (sd_uart[i])
        );

        servo_pwm u_pwm (
            .clock (clock),
            .rst_n (rst_n),
            .ratio (servo_position[i]),
            .pwm   (servo_pwm[i])
        );
    end

endmodule

// File: include/tb_spi_host.svh
////////////////////////////////////////////////////////////////////////////
// Testbench host tasks: SPI frames, UART frame capture, PWM duty count
////////////////////////////////////////////////////////////////////////////
`ifndef TB_SPI_HOST_SVH
`define TB_SPI_HOST_SVH

// One 16-bit mode 0 frame, command byte then data byte
task automatic spi_transfer(input logic wr, input reg_addr_t addr,
                            input reg_data_t wdata, output reg_data_t rdata);
    logic [15:0] frame;                              // Bits sent on mosi
    logic [15:0] rx;                                 // Bits seen on miso
    frame = {wr, 1'b0, addr, wdata};
    rx    = '0;
    @(negedge clock);
    cs_n = 1'b0;                                     // Select slave
    repeat (SPI_HALF) @(negedge clock);
    for (int i = 15; i >= 0; i--) begin
        mosi = frame[i];                             // MSB first, set while clock low
        repeat (SPI_HALF) @(negedge clock);
        spi_clock = 1'b1;
        rx = {rx[14:0], miso};                       // Host samples on rising edge
        repeat (SPI_HALF) @(negedge clock);
        spi_clock = 1'b0;
    end
    repeat (SPI_HALF) @(negedge clock);
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (SPI_HALF) @(negedge clock);
    rdata = rx[7:0];                                 // Second byte is the readback
endtask

// Skip the frame in progress, then decode the next one mid-bit
task automatic capture_uart(input int motor, output reg_data_t value,
                            output logic [1:0] framing);
    reg_data_t bits;                                 // Data bits, LSB first
    do @(negedge clock); while ((since_reset % UART_FRAME) != 1);
    repeat (2) @(negedge clock);                     // Middle of start bit
    framing[0] = sd_uart[motor];
    for (int b = 0; b < 8; b++) begin
        repeat (BAUD) @(negedge clock);
        bits[b] = sd_uart[motor];
    end
    repeat (BAUD) @(negedge clock);                  // Middle of stop bit
    framing[1] = sd_uart[motor];
    value = bits;
endtask

// High clocks of one servo line over one PWM period
task automatic count_high(input int idx, output int high);
    high = 0;
    repeat (PWM_PERIOD) begin
        @(negedge clock);
        if (servo_pwm[idx]) begin
            high++;
        end
    end
endtask

`endif

// File: tests/tb_fpga_subsys.sv
////////////////////////////////////////////////////////////////////////////
// Register subsystem testbench
// SPI register map, drive UART frames, servo duty and status lamps
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fpga_subsys import fpga_subsys_pkg::*; ();

    localparam int BAUD        = 6;                  // UART clocks per bit
    localparam int SPI_HALF    = 5;                  // Clocks per SPI half period
    localparam int UART_FRAME  = 10 * BAUD;          // Start, 8 data, stop
    localparam int PWM_PERIOD  = 256;
    localparam int NUM_ENTRIES = 14;
    localparam int NUM_FRAMES  = 2 * NUM_ENTRIES + 11 + 1;  // Table, reset reads, LED test
    localparam int TIMEOUT     = 2 * (NUM_FRAMES * 160 + 20 * UART_FRAME + 4 * PWM_PERIOD);

    // One table row, write data and the readback it must give
    typedef struct packed {
        reg_addr_t addr;                             // Register address
        reg_data_t wdata;                            // Value written
        reg_data_t exp_rd;                           // Value read back
        logic      live_fault;                       // Readback is the fault pattern
    } stim_entry_t;

    logic                  clock;
    logic                  rst_n;
    logic                  spi_clock;
    logic                  cs_n;
    logic                  mosi;
    logic                  miso;
    logic [NUM_MOTORS-1:0] motor_fault;
    logic [NUM_MOTORS-1:0] sd_uart;
    logic [NUM_MOTORS-1:0] servo_pwm;
    status_led_t           status_led;

    int unsigned cycle_count = 0;                    // Timeout counter
    int unsigned since_reset = 0;                    // Clocks since reset release
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] fault_word;                         // Random source for faults
    logic        model_pi;                           // Expected link and LED state
    logic        model_ps4;
    logic        model_test_en;
    logic [3:0]  model_test_val;

    stim_entry_t stim [NUM_ENTRIES] = '{
        '{addr: 6'h00, wdata: 8'hA5, exp_rd: 8'hA5, live_fault: 1'b0},  // Drive 0
        '{addr: 6'h01, wdata: 8'h3C, exp_rd: 8'h3C, live_fault: 1'b0},
        '{addr: 6'h02, wdata: 8'h5F, exp_rd: 8'h5F, live_fault: 1'b0},
        '{addr: 6'h03, wdata: 8'hC1, exp_rd: 8'hC1, live_fault: 1'b0},
        '{addr: 6'h04, wdata: 8'h00, exp_rd: 8'h00, live_fault: 1'b0},  // Servo edge cases
        '{addr: 6'h05, wdata: 8'h01, exp_rd: 8'h01, live_fault: 1'b0},
        '{addr: 6'h06, wdata: 8'h80, exp_rd: 8'h80, live_fault: 1'b0},
        '{addr: 6'h07, wdata: 8'hFF, exp_rd: 8'hFF, live_fault: 1'b0},
        '{addr: 6'h09, wdata: 8'h03, exp_rd: 8'h03, live_fault: 1'b0},  // Both links up
        '{addr: 6'h09, wdata: 8'hFE, exp_rd: 8'h02, live_fault: 1'b0},  // Upper bits dropped
        '{addr: 6'h08, wdata: 8'h0A, exp_rd: 8'h0A, live_fault: 1'b0},  // Test values, test off
        '{addr: 6'h0A, wdata: 8'hFF, exp_rd: 8'h00, live_fault: 1'b1},  // Read only
        '{addr: 6'h15, wdata: 8'h77, exp_rd: 8'h00, live_fault: 1'b0},  // Unmapped
        '{addr: 6'h3F, wdata: 8'h5A, exp_rd: 8'h00, live_fault: 1'b0}
    };

    fpga_subsys #(.BAUD_DIVISION(BAUD)) dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .spi_clock   (spi_clock),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .miso        (miso),
        .motor_fault (motor_fault),
        .sd_uart     (sd_uart),
        .servo_pwm   (servo_pwm),
        .status_led  (status_led)
    );

    `include "tb_spi_host.svh"

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;                   // 8 ns period
    end

    always @(posedge clock) begin
        if (rst_n) begin
            since_reset <= since_reset + 1;          // UART frame phase reference
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and lamp model
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_byte(input reg_data_t got, input reg_data_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_cmd(input drive_cmd_t got, input drive_cmd_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s got brk %b en %b dir %b spd %0d, expected %b %b %b %0d",
                     $time, what, got.brake, got.enable, got.direction, got.speed,
                     exp.brake, exp.enable, exp.direction, exp.speed);
        end
    endtask

    task automatic check_leds(input status_led_t got, input status_led_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s lamps %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_duty(input int high, input reg_data_t ratio, input string what);
        check_count++;
        if (high != int'(ratio)) begin
            error_count++;
            $display("ERROR %0t: %s high for %0d clocks, ratio %0d", $time, what, high, ratio);
        end
    endtask

    function automatic status_led_t expected_leds();
        status_led_t exp;
        if (model_test_en) begin
            exp = status_led_t'(model_test_val);     // Test bits override all lamps
        end else begin
            exp.fault = |motor_fault;
            exp.pi    = model_pi;
            exp.ps4   = model_ps4;
            exp.debug = 1'b1;
        end
        return exp;
    endfunction

    task automatic update_model(input reg_addr_t addr, input reg_data_t data);
        if (addr == ADDR_LINK) begin
            model_pi  = data[0];
            model_ps4 = data[1];
        end else if (addr == ADDR_LED_CTRL) begin
            model_test_en  = data[4];
            model_test_val = data[3:0];
        end
    endtask

    task automatic new_fault();
        fault_word  = $urandom;
        motor_fault = fault_word[NUM_MOTORS-1:0];
    endtask

    // Random faults, lamps checked one clock after each change
    task automatic fault_sweep(input string what);
        repeat (6) begin
            @(negedge clock);
            new_fault();
            @(negedge clock);
            check_leds(status_led, expected_leds(), what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reg_data_t  rd;
        reg_data_t  exp;
        reg_data_t  rx_byte;
        logic [1:0] framing;
        int         high;
        int         idx;
        void'($urandom(78043));
        rst_n          = 1'b0;
        spi_clock      = 1'b0;
        cs_n           = 1'b1;
        mosi           = 1'b0;
        model_pi       = 1'b0;
        model_ps4      = 1'b0;
        model_test_en  = 1'b0;
        model_test_val = '0;
        new_fault();
        repeat (10) begin
            @(negedge clock);
            check_byte({4'b0, sd_uart}, 8'h0F, "UART lines in reset");
        end
        rst_n = 1'b1;
        @(negedge clock);
        check_leds(status_led, expected_leds(), "lamps after reset");
        for (int s = 0; s < NUM_MOTORS; s++) begin
            count_high(s, high);
            check_duty(high, 8'h00, "servo after reset");
        end
        for (int a = 0; a <= 10; a++) begin           // Every mapped register
            spi_transfer(1'b0, a[ADDR_W-1:0], 8'h00, rd);
            exp = (a[ADDR_W-1:0] == ADDR_FAULT) ? {4'b0, motor_fault} : 8'h00;
            check_byte(rd, exp, "readback after reset");
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stim[i].live_fault) begin
                new_fault();
            end
            spi_transfer(1'b1, stim[i].addr, stim[i].wdata, rd);
            update_model(stim[i].addr, stim[i].wdata);
            spi_transfer(1'b0, stim[i].addr, 8'h00, rd);
            exp = stim[i].live_fault ? {4'b0, motor_fault} : stim[i].exp_rd;
            check_byte(rd, exp, "register readback");
            check_leds(status_led, expected_leds(), "lamps after table entry");
            idx = int'(stim[i].addr[1:0]);
            if (stim[i].addr < ADDR_SERVO0) begin
                capture_uart(idx, rx_byte, framing);
                check_byte({6'b0, framing}, 8'h02, "UART start and stop bits");
                check_cmd(drive_cmd_t'(rx_byte), drive_cmd_t'(stim[i].wdata), "UART frame");
            end else if (stim[i].addr < ADDR_LED_CTRL) begin
                repeat (2 * PWM_PERIOD) @(negedge clock);
                count_high(idx, high);
                check_duty(high, stim[i].wdata, "servo duty");
            end
        end

        fault_sweep("lamps with test off");
        spi_transfer(1'b1, ADDR_LED_CTRL, 8'h14, rd);  // Test on, values 0100
        update_model(ADDR_LED_CTRL, 8'h14);
        fault_sweep("lamps with test on");

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
logic/fpga_subsys_pkg.sv
logic/spi_slave.sv
logic/reg_file.sv
logic/uart_tx.sv
logic/servo_pwm.sv
logic/fpga_subsys.sv
tests/tb_fpga_subsys.sv

// File: Makefile
# Verilator simulation of the register subsystem

TOOL  = verilator
FLAGS = --binary -j 0
TOP   = tb_fpga_subsys
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass message
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
